// ==== sources.f ====
+incdir+design
design/bus_pkg.sv
design/byte_ram.sv
design/mbus_ctrl.sv
design/zbus_ctrl.sv
design/bus_top.sv
testbench/bus_checker.sv
testbench/bus_sva.sv
testbench/bus_tb.sv

// ==== Makefile ====
# Verilator build and run of the bus controller testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := bus_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/bus_tb.sv ====
/*
 * Bus controller testbench
 * Applies a table of 68K and Z80 accesses and reports the verdict
 */
`include "bus_cfg.svh"

module bus_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NAME_LEN = 20;
	localparam int MAX_TESTS = 48;
	localparam logic [1:0] KIND_68K = 2'd0;
	localparam logic [1:0] KIND_BANK = 2'd1;
	localparam logic [1:0] KIND_ZDIR = 2'd2;
	localparam logic [8:0] BANK_VAL = 9'h1C3;

	logic MCLK;
	logic reset;
	logic m68k_as_n;
	bus_pkg::mbus_addr_t m68k_addr;
	logic m68k_rnw;
	logic m68k_uds_n;
	logic m68k_lds_n;
	logic [15:0] m68k_wdata;
	logic [15:0] m68k_rdata;
	logic m68k_dtack_n;
	bus_pkg::z80_addr_t z80_addr;
	logic z80_mreq_n;
	logic z80_rd_n;
	logic z80_wr_n;
	logic [7:0] z80_wdata;
	logic [7:0] z80_mbus_rdata;
	logic z80_mbus_dtack_n;
	logic [7:0] z80_zbus_rdata;
	logic z80_zbus_dtack_n;
	logic z80_busrq_n;
	logic z80_reset_n;

	// Current test as seen by the checker
	logic [8*NAME_LEN-1:0] cur_name;
	logic [1:0] cur_kind;
	logic cur_read;
	logic [15:0] cur_exp;
	// Expected busrq_n in bit 1 and reset_n in bit 0
	logic [1:0] cur_ctrl;
	logic start;
	int n_done;
	int n_errors;

	//--------------------------------------------------
	// Stimulus table
	//--------------------------------------------------
	// Name, port, address, direction, lanes, write data and expected read data
	string       t_name [MAX_TESTS];
	logic        t_z80 [MAX_TESTS];
	logic [23:0] t_addr [MAX_TESTS];
	logic        t_read [MAX_TESTS];
	logic [1:0]  t_lanes [MAX_TESTS];
	logic [15:0] t_wdata [MAX_TESTS];
	logic [15:0] t_exp [MAX_TESTS];
	int          n_tests = 0;
	integer      seed;
	int          cycles = 0;
	int          cycle_limit = 0;

	bus_top uut (.*);

	bus_checker #(.NAME_LEN(NAME_LEN)) u_check (
		.MCLK(MCLK), .start(start), .test_name(cur_name), .kind(cur_kind),
		.check_read(cur_read), .expected(cur_exp), .expected_ctrl(cur_ctrl),
		.m68k_dtack_n(m68k_dtack_n), .m68k_rdata(m68k_rdata),
		.z80_mbus_dtack_n(z80_mbus_dtack_n), .z80_mbus_rdata(z80_mbus_rdata),
		.z80_zbus_dtack_n(z80_zbus_dtack_n), .z80_zbus_rdata(z80_zbus_rdata),
		.z80_busrq_n(z80_busrq_n), .z80_reset_n(z80_reset_n),
		.n_done(n_done), .n_errors(n_errors)
	);

	initial begin
		MCLK = 1'b0;
		forever #10 MCLK = ~MCLK;
	end

	task automatic add_test(input string name, input logic z80, input logic [23:0] addr,
		input logic rd, input logic [1:0] lanes, input logic [15:0] wdata,
		input logic [15:0] exp);
		t_name[n_tests] = name;
		t_z80[n_tests] = z80;
		t_addr[n_tests] = addr;
		t_read[n_tests] = rd;
		t_lanes[n_tests] = lanes;
		t_wdata[n_tests] = wdata;
		t_exp[n_tests] = exp;
		n_tests++;
	endtask

	// Lane bit 1 is the upper byte and bit 0 the lower byte
	task automatic build_table();
		logic [31:0] rnd;
		logic [15:0] r_w0, r_up, r_lo, r_w1, r_w2;
		logic [7:0] z_pre, zb0, zb1, zb2, zb3;
		seed = 32'hb1ddeb80;
		rnd = $random(seed);
		r_w0 = rnd[15:0];
		rnd = $random(seed);
		r_up = rnd[15:0];
		rnd = $random(seed);
		r_lo = rnd[15:0];
		rnd = $random(seed);
		r_w1 = rnd[15:0];
		rnd = $random(seed);
		r_w2 = rnd[15:0];
		rnd = $random(seed);
		z_pre = rnd[7:0];
		zb0 = rnd[15:8];
		rnd = $random(seed);
		zb1 = rnd[7:0];
		zb2 = rnd[15:8];
		zb3 = rnd[23:16];
		// Out of reset the Z80 bus is not free
		add_test("z80_pre_write", 1, 24'h000040, 0, 2'b00, {8'h00, z_pre}, 16'h0);
		add_test("ctrl_busrq_rst", 0, 24'hA11100, 1, 2'b11, 16'h0, 16'hFFFF);
		add_test("ctrl_reset_rst", 0, 24'hA11200, 1, 2'b11, 16'h0, 16'hFEFF);
		add_test("zram_wr_blocked", 0, 24'hA00040, 0, 2'b10, {~z_pre, 8'h00}, 16'h0);
		add_test("zram_rd_blocked", 0, 24'hA00040, 1, 2'b11, 16'h0,
			{`ZBUS_IDLE_BYTE, `ZBUS_IDLE_BYTE});
		// Work RAM lane merging
		add_test("wram_word_wr", 0, 24'hE00010, 0, 2'b11, r_w0, 16'h0);
		add_test("wram_upper_wr", 0, 24'hE00010, 0, 2'b10, r_up, 16'h0);
		add_test("wram_merge_hi", 0, 24'hE00010, 1, 2'b11, 16'h0, {r_up[15:8], r_w0[7:0]});
		add_test("wram_lower_wr", 0, 24'hE00010, 0, 2'b01, r_lo, 16'h0);
		add_test("wram_merge_lo", 0, 24'hE00010, 1, 2'b11, 16'h0, {r_up[15:8], r_lo[7:0]});
		add_test("wram_word2_wr", 0, 24'hE0ABCE, 0, 2'b11, r_w1, 16'h0);
		add_test("wram_word2_rd", 0, 24'hE0ABCE, 1, 2'b11, 16'h0, r_w1);
		// Take the Z80 bus
		add_test("grant_busrq", 0, 24'hA11100, 0, 2'b10, 16'h0100, 16'h0);
		add_test("release_reset", 0, 24'hA11200, 0, 2'b10, 16'h0100, 16'h0);
		add_test("ctrl_busrq_set", 0, 24'hA11100, 1, 2'b11, 16'h0, 16'hFEFF);
		add_test("ctrl_reset_set", 0, 24'hA11200, 1, 2'b11, 16'h0, 16'hFFFF);
		add_test("zram_keep_pre", 0, 24'hA00040, 1, 2'b11, 16'h0, {z_pre, z_pre});
		add_test("zram_even_wr", 0, 24'hA00010, 0, 2'b10, {zb0, ~zb0}, 16'h0);
		add_test("zram_odd_wr", 0, 24'hA00010, 0, 2'b01, {~zb1, zb1}, 16'h0);
		add_test("zram_even_rd", 0, 24'hA00010, 1, 2'b11, 16'h0, {zb0, zb0});
		add_test("zram_odd_rd", 0, 24'hA00010, 1, 2'b01, 16'h0, {zb1, zb1});
		add_test("zram_mirror_rd", 0, 24'hA02010, 1, 2'b11, 16'h0, {zb0, zb0});
		// Z80 direct port against the same bytes
		add_test("z80_rd_even", 1, 24'h000010, 1, 2'b00, 16'h0, {8'h00, zb0});
		add_test("z80_rd_mirror", 1, 24'h002011, 1, 2'b00, 16'h0, {8'h00, zb1});
		add_test("z80_wr", 1, 24'h000020, 0, 2'b00, {8'h00, zb2}, 16'h0);
		add_test("zram_rd_z80", 0, 24'hA00020, 1, 2'b11, 16'h0, {zb2, zb2});
		add_test("zram_lo_wr", 0, 24'hA00030, 0, 2'b01, {8'h00, zb3}, 16'h0);
		add_test("z80_rd_68k", 1, 24'h000031, 1, 2'b00, 16'h0, {8'h00, zb3});
		// Nine bank writes leave the first bit in bank bit 0
		for (int b = 0; b < 9; b++) begin
			add_test("bank_shift", 1, 24'h006000, 0, 2'b00, {15'h0, BANK_VAL[b]}, 16'h0);
		end
		add_test("wram_bank_wr", 0, {BANK_VAL, 15'h1234}, 0, 2'b11, r_w2, 16'h0);
		add_test("z80_bank_rd_odd", 1, {8'h00, 1'b1, 15'h1235}, 1, 2'b00, 16'h0,
			{8'h00, r_w2[7:0]});
		add_test("z80_bank_rd_even", 1, {8'h00, 1'b1, 15'h1234}, 1, 2'b00, 16'h0,
			{8'h00, r_w2[15:8]});
		add_test("unmapped_rd", 0, 24'h400000, 1, 2'b11, 16'h0, `OPEN_BUS);
		add_test("unmapped_rd_hi", 0, 24'hC00000, 1, 2'b11, 16'h0, `OPEN_BUS);
		cycle_limit = 40 * n_tests + 100;
	endtask

	// Name padded with spaces on the left for the checker
	function automatic logic [8*NAME_LEN-1:0] name_bits(input string s);
		logic [8*NAME_LEN-1:0] v;
		v = {NAME_LEN{8'h20}};
		for (int i = 0; i < s.len(); i++) begin
			v = {v[8*NAME_LEN-9:0], s[i]};
		end
		return v;
	endfunction

	function automatic logic ack_level(input logic [1:0] kind);
		case (kind)
			KIND_68K: return m68k_dtack_n;
			KIND_BANK: return z80_mbus_dtack_n;
			default: return z80_zbus_dtack_n;
		endcase
	endfunction

	task automatic wait_ack(input logic [1:0] kind, input logic level);
		while (ack_level(kind) != level) begin
			@(negedge MCLK);
		end
	endtask

	task automatic run_test(input int i);
		logic [1:0] kind;
		kind = !t_z80[i] ? KIND_68K : (t_addr[i][15] ? KIND_BANK : KIND_ZDIR);
		@(negedge MCLK);
		// Bit 8 of an upper-byte control write sets the register
		if (kind == KIND_68K && !t_read[i] && t_lanes[i][1]) begin
			if (t_addr[i] == 24'hA11100) cur_ctrl[1] = ~t_wdata[i][8];
			if (t_addr[i] == 24'hA11200) cur_ctrl[0] = t_wdata[i][8];
		end
		cur_name = name_bits(t_name[i]);
		cur_kind = kind;
		cur_read = t_read[i];
		cur_exp = t_exp[i];
		start = 1'b1;
		if (kind == KIND_68K) begin
			m68k_addr = t_addr[i][23:1];
			m68k_rnw = t_read[i];
			m68k_uds_n = ~t_lanes[i][1];
			m68k_lds_n = ~t_lanes[i][0];
			m68k_wdata = t_wdata[i];
			m68k_as_n = 1'b0;
		end else begin
			z80_addr = t_addr[i][15:0];
			z80_wdata = t_wdata[i][7:0];
			z80_rd_n = ~t_read[i];
			z80_wr_n = t_read[i];
			z80_mreq_n = 1'b0;
		end
		@(negedge MCLK);
		start = 1'b0;
		wait_ack(kind, 1'b0);
		m68k_as_n = 1'b1;
		z80_mreq_n = 1'b1;
		z80_rd_n = 1'b1;
		z80_wr_n = 1'b1;
		wait_ack(kind, 1'b1);
	endtask

	// Run limit from the table length
	always @(posedge MCLK) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: no acknowledge");
			$display("TESTS FAILED");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		m68k_as_n = 1'b1;
		m68k_addr = '0;
		m68k_rnw = 1'b1;
		m68k_uds_n = 1'b1;
		m68k_lds_n = 1'b1;
		m68k_wdata = 16'h0;
		z80_addr = '0;
		z80_mreq_n = 1'b1;
		z80_rd_n = 1'b1;
		z80_wr_n = 1'b1;
		z80_wdata = 8'h0;
		start = 1'b0;
		cur_name = '0;
		cur_kind = KIND_68K;
		cur_read = 1'b0;
		cur_exp = 16'h0;
		// Bus request released and Z80 held in reset
		cur_ctrl = 2'b10;
		build_table();
		repeat (4) @(posedge MCLK);
		@(negedge MCLK);
		reset = 1'b0;
		for (int i = 0; i < n_tests; i++) begin
			run_test(i);
		end
		repeat (2) @(negedge MCLK);
		$display("tests %0d of %0d done, %0d errors, %0d assertion failures",
			n_done, n_tests, n_errors, uut.u_mbus.u_sva.fail_count);
		if (n_errors == 0 && n_done == n_tests && uut.u_mbus.u_sva.fail_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== testbench/bus_sva.sv ====
/*
 * Main-bus protocol assertions bound into the main-bus controller
 */
module bus_sva (
	input logic MCLK,
	input logic reset,
	input logic m68k_as_n,
	input logic m68k_dtack_n,
	input logic z80_mbus_dtack_n,
	input logic zbus_sel,
	input logic zbus_dtack_n
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;

	// Held high through reset
	dtack_in_reset: assert property (@(posedge MCLK) reset |=> m68k_dtack_n)
		else begin
			fail_count++;
			$error("68K acknowledge low during reset");
		end

	// Released soon after the address strobe goes away
	dtack_release: assert property (@(posedge MCLK) disable iff (reset)
		$rose(m68k_as_n) |-> ##[0:2] m68k_dtack_n)
		else begin
			fail_count++;
			$error("68K acknowledge not released after strobe rose");
		end

	// One requester owns the main bus at a time
	one_owner: assert property (@(posedge MCLK) disable iff (reset)
		!(!m68k_dtack_n && !z80_mbus_dtack_n))
		else begin
			fail_count++;
			$error("68K and banked Z80 acknowledged together");
		end

	// Z80-bus acknowledge returns high on the edge after select drops
	zbus_release: assert property (@(posedge MCLK) disable iff (reset)
		!zbus_sel |=> zbus_dtack_n)
		else begin
			fail_count++;
			$error("Z80-bus acknowledge held after select dropped");
		end

endmodule

bind mbus_ctrl bus_sva u_sva (
	.MCLK(MCLK),
	.reset(reset),
	.m68k_as_n(m68k_as_n),
	.m68k_dtack_n(m68k_dtack_n),
	.z80_mbus_dtack_n(z80_mbus_dtack_n),
	.zbus_sel(zbus_sel),
	.zbus_dtack_n(zbus_dtack_n)
);

// ==== testbench/bus_checker.sv ====
/*
 * Result checker
 * Samples read data when the active acknowledge falls and keeps counts
 */
module bus_checker #(
	parameter int NAME_LEN = 20
) (
	input  logic                  MCLK,
	input  logic                  start,
	input  logic [8*NAME_LEN-1:0] test_name,
	input  logic [1:0]            kind,
	input  logic                  check_read,
	input  logic [15:0]           expected,
	input  logic [1:0]            expected_ctrl,
	input  logic                  m68k_dtack_n,
	input  logic [15:0]           m68k_rdata,
	input  logic                  z80_mbus_dtack_n,
	input  logic [7:0]            z80_mbus_rdata,
	input  logic                  z80_zbus_dtack_n,
	input  logic [7:0]            z80_zbus_rdata,
	input  logic                  z80_busrq_n,
	input  logic                  z80_reset_n,
	output int                    n_done,
	output int                    n_errors
);
	timeunit 1ns;
	timeprecision 100ps;

	logic        armed;
	logic        ack_n;
	logic [15:0] actual;

	// Kind 0 is the 68K, 1 the bank window and 2 the Z80 bus
	always_comb begin
		case (kind)
			2'd0: begin
				ack_n = m68k_dtack_n;
				actual = m68k_rdata;
			end
			2'd1: begin
				ack_n = z80_mbus_dtack_n;
				actual = {8'h00, z80_mbus_rdata};
			end
			default: begin
				ack_n = z80_zbus_dtack_n;
				actual = {8'h00, z80_zbus_rdata};
			end
		endcase
	end

	initial begin
		armed = 1'b0;
		n_done = 0;
		n_errors = 0;
	end

	always @(posedge MCLK) begin
		if (start) begin
			armed <= 1'b1;
		end else if (armed && !ack_n) begin
			armed <= 1'b0;
			n_done <= n_done + 1;
			if ({z80_busrq_n, z80_reset_n} !== expected_ctrl) begin
				n_errors <= n_errors + 1;
				$display("ERR %s expected busrq_n/reset_n %b actual %b", test_name,
					expected_ctrl, {z80_busrq_n, z80_reset_n});
			end else if (!check_read) begin
				$display("ok   %s  write taken", test_name);
			end else if (actual === expected) begin
				$display("ok   %s  read %h", test_name, actual);
			end else begin
				n_errors <= n_errors + 1;
				$display("ERR %s expected %h actual %h", test_name, expected, actual);
			end
		end
	end

endmodule

// ==== design/bus_top.sv ====
/*
 * Console bus controller top
 * Main-bus controller with work RAM, Z80-bus controller with Z80 RAM
 */
module bus_top (
	input  logic                MCLK,
	input  logic                reset,

	// 68K port
	input  logic                m68k_as_n,
	input  bus_pkg::mbus_addr_t m68k_addr,
	input  logic                m68k_rnw,
	input  logic                m68k_uds_n,
	input  logic                m68k_lds_n,
	input  logic [15:0]         m68k_wdata,
	output logic [15:0]         m68k_rdata,
	output logic                m68k_dtack_n,

	// Z80 port
	input  bus_pkg::z80_addr_t  z80_addr,
	input  logic                z80_mreq_n,
	input  logic                z80_rd_n,
	input  logic                z80_wr_n,
	input  logic [7:0]          z80_wdata,
	output logic [7:0]          z80_mbus_rdata,
	output logic                z80_mbus_dtack_n,
	output logic [7:0]          z80_zbus_rdata,
	output logic                z80_zbus_dtack_n,

	// Z80 control
	output logic                z80_busrq_n,
	output logic                z80_reset_n
);

	// Main bus to Z80 bus
	logic        zbus_sel;
	logic [14:0] zbus_addr;
	logic [7:0]  zbus_wdata;
	logic        zbus_write;
	logic        zbus_free;
	logic [7:0]  zbus_rdata;
	logic        zbus_dtack_n;
	logic [8:0]  bank;

	mbus_ctrl u_mbus (
		.MCLK(MCLK),
		.reset(reset),
		.m68k_as_n(m68k_as_n),
		.m68k_addr(m68k_addr),
		.m68k_rnw(m68k_rnw),
		.m68k_uds_n(m68k_uds_n),
		.m68k_lds_n(m68k_lds_n),
		.m68k_wdata(m68k_wdata),
		.z80_addr(z80_addr),
		.z80_mreq_n(z80_mreq_n),
		.z80_rd_n(z80_rd_n),
		.z80_wr_n(z80_wr_n),
		.z80_wdata(z80_wdata),
		.zbus_rdata(zbus_rdata),
		.zbus_dtack_n(zbus_dtack_n),
		.bank(bank),
		.m68k_rdata(m68k_rdata),
		.m68k_dtack_n(m68k_dtack_n),
		.z80_mbus_rdata(z80_mbus_rdata),
		.z80_mbus_dtack_n(z80_mbus_dtack_n),
		.z80_busrq_n(z80_busrq_n),
		.z80_reset_n(z80_reset_n),
		.zbus_sel(zbus_sel),
		.zbus_addr(zbus_addr),
		.zbus_wdata(zbus_wdata),
		.zbus_write(zbus_write),
		.zbus_free(zbus_free)
	);

	zbus_ctrl u_zbus (
		.MCLK(MCLK),
		.reset(reset),
		.zbus_sel(zbus_sel),
		.zbus_addr(zbus_addr),
		.zbus_wdata(zbus_wdata),
		.zbus_write(zbus_write),
		.zbus_free(zbus_free),
		.z80_addr(z80_addr),
		.z80_mreq_n(z80_mreq_n),
		.z80_rd_n(z80_rd_n),
		.z80_wr_n(z80_wr_n),
		.z80_wdata(z80_wdata),
		.zbus_rdata(zbus_rdata),
		.zbus_dtack_n(zbus_dtack_n),
		.z80_zbus_rdata(z80_zbus_rdata),
		.z80_zbus_dtack_n(z80_zbus_dtack_n),
		.bank(bank)
	);

endmodule

// ==== design/zbus_ctrl.sv ====
/*
 * Z80-bus controller
 * Shares the Z80 RAM between the main bus and the Z80, holds the bank register
 */
`include "bus_cfg.svh"

module zbus_ctrl (
	input  logic               MCLK,
	input  logic               reset,
	input  logic               zbus_sel,
	input  logic [14:0]        zbus_addr,
	input  logic [7:0]         zbus_wdata,
	input  logic               zbus_write,
	input  logic               zbus_free,
	input  bus_pkg::z80_addr_t z80_addr,
	input  logic               z80_mreq_n,
	input  logic               z80_rd_n,
	input  logic               z80_wr_n,
	input  logic [7:0]         z80_wdata,
	output logic [7:0]         zbus_rdata,
	output logic               zbus_dtack_n,
	output logic [7:0]         z80_zbus_rdata,
	output logic               z80_zbus_dtack_n,
	output logic [8:0]         bank
);

	localparam logic [1:0] Z_IDLE   = 2'd0;
	localparam logic [1:0] Z_READ   = 2'd1;
	localparam logic [1:0] Z_FINISH = 2'd2;

	logic [1:0]  zstate;
	logic        src_z80;
	logic [14:0] za;
	logic [7:0]  zdo;
	logic        zwe;
	logic [7:0]  zram_q;
	logic [7:0]  zbus_di;

	// Direct Z80 access below 8000, the 7Fxx page gets no answer
	logic z80_sel;
	assign z80_sel = ~z80_mreq_n & (~z80_rd_n | ~z80_wr_n) & ~z80_addr.zbus.top &
		(z80_addr.zbus.page != `ZVDP_PAGE);

	// RAM at 0000-3FFF, mirrored every 2000
	logic zram_hit;
	assign zram_hit = ~za[14];
	assign zbus_di  = zram_hit ? zram_q : `ZBUS_IDLE_BYTE;

	byte_ram #(.ADDR_W(`ZRAM_AW)) zram (
		.MCLK(MCLK),
		.addr(za[`ZRAM_AW-1:0]),
		.wdata(zdo),
		.we(zwe & zram_hit),
		.rdata(zram_q)
	);

	//--------------------------------------------------
	// Arbiter, main bus ahead of the Z80
	//--------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			zstate <= Z_IDLE;
			src_z80 <= 1'b0;
			zwe <= 1'b0;
			zbus_dtack_n <= 1'b1;
			z80_zbus_dtack_n <= 1'b1;
		end else begin
			zwe <= 1'b0;
			if (~zbus_sel) zbus_dtack_n <= 1'b1;
			if (~z80_sel) z80_zbus_dtack_n <= 1'b1;

			case (zstate)
				Z_IDLE: begin
					if (zbus_sel & zbus_dtack_n) begin
						za <= zbus_addr;
						zdo <= zbus_wdata;
						// Writes only land while the Z80 is off the bus
						zwe <= zbus_write & zbus_free;
						src_z80 <= 1'b0;
						zstate <= Z_READ;
					end else if (z80_sel & z80_zbus_dtack_n) begin
						za <= {z80_addr.zbus.page, z80_addr.zbus.low};
						zdo <= z80_wdata;
						zwe <= ~z80_wr_n;
						src_z80 <= 1'b1;
						zstate <= Z_READ;
					end
				end

				Z_READ: zstate <= Z_FINISH;

				Z_FINISH: begin
					if (src_z80) begin
						z80_zbus_rdata <= zbus_di;
						z80_zbus_dtack_n <= 1'b0;
					end else begin
						zbus_rdata <= zbus_free ? zbus_di : `ZBUS_IDLE_BYTE;
						zbus_dtack_n <= 1'b0;
					end
					zstate <= Z_IDLE;
				end

				default: zstate <= Z_IDLE;
			endcase
		end
	end

	// Bank register at page 60, one bit per write, filled from the top
	always_ff @(posedge MCLK) begin
		if (reset) begin
			bank <= 9'd0;
		end else if (zwe && za[14:8] == `BANK_PAGE) begin
			bank <= {zdo[0], bank[8:1]};
		end
	end

endmodule

// ==== design/mbus_ctrl.sv ====
/*
 * Main-bus controller
 * Arbitrates 68K and banked Z80 cycles, decodes regions, owns work RAM
 */
`include "bus_cfg.svh"

module mbus_ctrl (
	input  logic                MCLK,
	input  logic                reset,
	input  logic                m68k_as_n,
	input  bus_pkg::mbus_addr_t m68k_addr,
	input  logic                m68k_rnw,
	input  logic                m68k_uds_n,
	input  logic                m68k_lds_n,
	input  logic [15:0]         m68k_wdata,
	input  bus_pkg::z80_addr_t  z80_addr,
	input  logic                z80_mreq_n,
	input  logic                z80_rd_n,
	input  logic                z80_wr_n,
	input  logic [7:0]          z80_wdata,
	input  logic [7:0]          zbus_rdata,
	input  logic                zbus_dtack_n,
	input  logic [8:0]          bank,
	output logic [15:0]         m68k_rdata,
	output logic                m68k_dtack_n,
	output logic [7:0]          z80_mbus_rdata,
	output logic                z80_mbus_dtack_n,
	output logic                z80_busrq_n,
	output logic                z80_reset_n,
	output logic                zbus_sel,
	output logic [14:0]         zbus_addr,
	output logic [7:0]          zbus_wdata,
	output logic                zbus_write,
	output logic                zbus_free
);

	localparam logic [2:0] S_IDLE      = 3'd0;
	localparam logic [2:0] S_SELECT    = 3'd1;
	localparam logic [2:0] S_RAM_READ  = 3'd2;
	localparam logic [2:0] S_ZBUS_WAIT = 3'd3;
	localparam logic [2:0] S_FINISH    = 3'd4;

	logic [2:0]          mstate;
	bus_pkg::mbus_src_e  msrc;

	// Latched cycle
	bus_pkg::mbus_addr_t mbus_a;
	logic [15:0]         mbus_wdata;
	logic                mbus_rnw;
	logic                mbus_uds_n;
	logic                mbus_lds_n;
	logic [15:0]         data;

	logic                ram_sel;
	logic [15:0]         wram_q;

	// Z80 strobes, bit 15 set means the bank window
	logic z80_io;
	logic z80_bank_req;
	assign z80_io       = ~z80_mreq_n & (~z80_rd_n | ~z80_wr_n);
	assign z80_bank_req = z80_io & z80_addr.bank.win;

	//--------------------------------------------------
	// Region decode on the latched address
	//--------------------------------------------------
	logic wram_hit;
	logic zbus_hit;
	logic ctrl_busrq_hit;
	logic ctrl_reset_hit;

	assign wram_hit = mbus_a[23:21] == `WRAM_TOP;
	assign zbus_hit = mbus_a[23:16] == `ZBUS_TOP;
	assign ctrl_busrq_hit = mbus_a[23:12] == `CTRL_TOP && mbus_a[11:8] == `CTRL_BUSRQ &&
		mbus_a[7:1] == 7'd0;
	assign ctrl_reset_hit = mbus_a[23:12] == `CTRL_TOP && mbus_a[11:8] == `CTRL_RESET &&
		mbus_a[7:1] == 7'd0;

	// Z80 bus side, byte lane picked by the upper strobe
	assign zbus_addr  = {mbus_a[14:1], mbus_uds_n};
	assign zbus_wdata = mbus_uds_n ? mbus_wdata[7:0] : mbus_wdata[15:8];
	assign zbus_write = ~mbus_rnw;
	assign zbus_free  = ~z80_busrq_n & z80_reset_n;

	byte_ram #(.ADDR_W(`WRAM_AW)) wram_hi (
		.MCLK(MCLK),
		.addr(mbus_a[`WRAM_AW:1]),
		.wdata(mbus_wdata[15:8]),
		.we(ram_sel & ~mbus_rnw & ~mbus_uds_n),
		.rdata(wram_q[15:8])
	);

	byte_ram #(.ADDR_W(`WRAM_AW)) wram_lo (
		.MCLK(MCLK),
		.addr(mbus_a[`WRAM_AW:1]),
		.wdata(mbus_wdata[7:0]),
		.we(ram_sel & ~mbus_rnw & ~mbus_lds_n),
		.rdata(wram_q[7:0])
	);

	//--------------------------------------------------
	// Bus cycle FSM
	//--------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			mstate <= S_IDLE;
			msrc <= bus_pkg::SRC_NONE;
			m68k_dtack_n <= 1'b1;
			z80_mbus_dtack_n <= 1'b1;
			zbus_sel <= 1'b0;
			ram_sel <= 1'b0;
			z80_busrq_n <= 1'b1;
			z80_reset_n <= 1'b0;
		end else begin
			// Acknowledges release one edge after the strobe goes away
			if (m68k_as_n) m68k_dtack_n <= 1'b1;
			if (~z80_io) z80_mbus_dtack_n <= 1'b1;

			case (mstate)
				S_IDLE: begin
					msrc <= bus_pkg::SRC_NONE;
					data <= `OPEN_BUS;
					// 68K first, the banked Z80 waits
					if (~m68k_as_n & m68k_dtack_n) begin
						msrc <= bus_pkg::SRC_M68K;
						mbus_a <= m68k_addr;
						mbus_wdata <= m68k_wdata;
						mbus_rnw <= m68k_rnw;
						mbus_uds_n <= m68k_uds_n;
						mbus_lds_n <= m68k_lds_n;
						mstate <= S_SELECT;
					end else if (z80_bank_req & z80_mbus_dtack_n) begin
						msrc <= bus_pkg::SRC_Z80;
						mbus_a <= {bank, z80_addr.bank.offset[14:1]};
						mbus_wdata <= {z80_wdata, z80_wdata};
						mbus_rnw <= z80_wr_n;
						mbus_uds_n <= z80_addr.bank.offset[0];
						mbus_lds_n <= ~z80_addr.bank.offset[0];
						mstate <= S_SELECT;
					end
				end

				S_SELECT: begin
					// Unmapped falls through with open bus data
					mstate <= S_FINISH;
					if (wram_hit) begin
						ram_sel <= 1'b1;
						mstate <= S_RAM_READ;
					end else if (zbus_hit) begin
						zbus_sel <= 1'b1;
						mstate <= S_ZBUS_WAIT;
					end else if (ctrl_busrq_hit | ctrl_reset_hit) begin
						data <= `OPEN_BUS;
						data[8] <= ctrl_busrq_hit ? z80_busrq_n : z80_reset_n;
						if (~mbus_rnw & ~mbus_uds_n) begin
							if (ctrl_busrq_hit) z80_busrq_n <= ~mbus_wdata[8];
							if (ctrl_reset_hit) z80_reset_n <= mbus_wdata[8];
						end
					end
				end

				S_RAM_READ: begin
					ram_sel <= 1'b0;
					data <= wram_q;
					mstate <= S_FINISH;
				end

				S_ZBUS_WAIT: begin
					if (~zbus_dtack_n) begin
						zbus_sel <= 1'b0;
						data <= {zbus_rdata, zbus_rdata};
						mstate <= S_FINISH;
					end
				end

				S_FINISH: begin
					// Hold here until the requester lets go
					case (msrc)
						bus_pkg::SRC_M68K: begin
							m68k_rdata <= data;
							if (m68k_as_n) mstate <= S_IDLE;
							else m68k_dtack_n <= 1'b0;
						end
						bus_pkg::SRC_Z80: begin
							z80_mbus_rdata <= ~mbus_lds_n ? data[7:0] : data[15:8];
							if (~z80_io) mstate <= S_IDLE;
							else z80_mbus_dtack_n <= 1'b0;
						end
						default: mstate <= S_IDLE;
					endcase
				end

				default: mstate <= S_IDLE;
			endcase
		end
	end

endmodule

// ==== design/byte_ram.sv ====
/*
 * Single-port byte RAM
 * Synchronous write, registered read with one cycle of latency
 */
module byte_ram #(
	parameter int ADDR_W = 13
) (
	input  logic              MCLK,
	input  logic [ADDR_W-1:0] addr,
	input  logic [7:0]        wdata,
	input  logic              we,
	output logic [7:0]        rdata
);

	logic [7:0] mem [0:(1 << ADDR_W) - 1];

	// Read returns the old contents on a write cycle
	always_ff @(posedge MCLK) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

// ==== design/bus_pkg.sv ====
/*
 * Bus controller types
 * Address layouts shared by the main-bus and Z80-bus controllers
 */
package bus_pkg;

	// 68K word address, A0 is carried by the data strobes
	typedef logic [23:1] mbus_addr_t;

	// Z80 address, read either as a bank window access
	// or as a page and offset on the Z80 bus
	typedef union packed {
		struct packed {
			logic        win;
			logic [14:0] offset;
		} bank;
		struct packed {
			logic       top;
			logic [6:0] page;
			logic [7:0] low;
		} zbus;
	} z80_addr_t;

	//--------------------------------------------------
	// Main-bus requester
	//--------------------------------------------------
	typedef enum logic [1:0] {
		SRC_NONE = 2'd0,
		SRC_M68K = 2'd1,
		SRC_Z80  = 2'd2
	} mbus_src_e;

endpackage

// ==== design/bus_cfg.svh ====
/*
 * Bus controller configuration
 * Address widths, region match codes and idle bus values
 */
`ifndef BUS_CFG_SVH
`define BUS_CFG_SVH

// Memory sizes
`define WRAM_AW 15
`define ZRAM_AW 13

// Values seen when nothing answers
`define OPEN_BUS 16'hFFFF
`define ZBUS_IDLE_BYTE 8'hFF

// 68K regions, matched on the upper address bits
`define WRAM_TOP 3'b111
`define ZBUS_TOP 8'hA0
`define CTRL_TOP 12'hA11
`define CTRL_BUSRQ 4'h1
`define CTRL_RESET 4'h2

// Z80 bus pages
`define BANK_PAGE 7'h60
`define ZVDP_PAGE 7'h7F

`endif
